/* trng_trace.txt */
# kind value: C command byte, N noise word fed bit 0 first, E expected reply byte
# all values in hex, records in the order they are applied
C 3F
E 06
N 66655A59
N A9A6A59A
C 31
E CD
E AB
E 34
E 12
N 65565655
N 59566659
C 31
E EF
E BE
E AD
E DE
N 00000000
N 00000000
N 55555555
N 55555555
C 31
E EE
N 55AAAA59
N 96AAAA59
C 31
E 0D
E F0
E 0D
E 60
C 55
C 3F
E 06

/* list.f */
+incdir+.
uart_pkg.sv
trng_pkg.sv
entropy_if.sv
uart_rx.sv
uart_tx.sv
entropy_collector.sv
host_controller.sv
trng_uart_top.sv
tb_trng_uart.sv

/* Bender.yml */
package:
  name: trng_uart

export_include_dirs:
  - .

sources:
  - uart_pkg.sv
  - trng_pkg.sv
  - entropy_if.sv
  - uart_rx.sv
  - uart_tx.sv
  - entropy_collector.sv
  - host_controller.sv
  - trng_uart_top.sv
  - target: test
    files:
      - tb_trng_uart.sv

/* tb_trng_uart.sv */
// Testbench for the UART random number service
// Trace reader, UART driver and monitor, noise feeder, reference model
`timescale 1ns/1ps
`include "trng_config.svh"

module tb_trng_uart;
	import uart_pkg::*;
	import trng_pkg::*;

	// Idle time after the last command, in cycles
	localparam int TAIL_CYCLES = 10 * `CLKS_PER_BIT;

	logic i_Clk;
	logic rst_n;
	logic rx;
	logic noise_bit;
	logic noise_valid;
	logic tx;
	logic noise_ready;
	logic led;

	int errors = 0;
	int tests = 0;
	int limit = 0;
	int cycle_cnt = 0;
	int trace_bytes = 0;

	// Trace records in file order
	logic [7:0]  rec_kind[$];
	logic [31:0] rec_val[$];
	int          rec_idx;

	// Noise stream and model results
	word_t noise_q[$];
	int    noise_bits = 0;
	int    noise_pos = 0;
	bit    fire;
	word_t model_word_q[$];
	logic  model_fail_q[$];

	// Expected bytes of the current command, bytes seen on tx
	byte_t exp_q[$];
	byte_t reply_q[$];
	byte_t mon_byte;
	int    mon_i;
	byte_t cmd;

	bit cmd_seen = 1'b0;
	bit idle_bad = 1'b0;
	bit idle_reported = 1'b0;

	trng_uart_top trng_uart_i
	(
		.i_Clk       (i_Clk),
		.rst_n       (rst_n),
		.rx          (rx),
		.noise_bit   (noise_bit),
		.noise_valid (noise_valid),
		.tx          (tx),
		.noise_ready (noise_ready),
		.led         (led)
	);

	always #2 i_Clk = ~i_Clk;

	always @(posedge i_Clk)
		cycle_cnt <= cycle_cnt + 1;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_byte(input byte_t got, input byte_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %0t tx_byte got %02h expected %02h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %0t word got %08h expected %08h", $time, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Trace and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		int fd;
		int c;
		int r;
		logic [31:0] val;
		fd = $fopen("trng_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open trng_trace.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				c = $fgetc(fd);
				// Comment lines run to the newline
				if (c == "#")
				begin
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
				end
				else if (c == "C" || c == "N" || c == "E")
				begin
					r = $fscanf(fd, "%h", val);
					if (r == 1)
					begin
						rec_kind.push_back(c[7:0]);
						rec_val.push_back(val);
						if (c == "N")
							noise_q.push_back(val);
						else
							trace_bytes++;
					end
				end
			end
			$fclose(fd);
		end
		noise_bits = noise_q.size() * `WORD_BITS;
	endtask

	// Stream bit p, bit 0 of each noise word first
	function automatic logic noise_at(input int p);
		word_t w;
		w = noise_q[p / `WORD_BITS];
		return w[p % `WORD_BITS];
	endfunction

	// Von Neumann pairs and repetition count over the whole stream
	task automatic build_model();
		int pos;
		int kept;
		int run;
		logic first_b;
		logic fail;
		word_t acc;
		kept = 0;
		run = 0;
		fail = 1'b0;
		acc = '0;
		for (pos = 0; pos + 1 < noise_bits; pos = pos + 2)
		begin
			first_b = noise_at(pos);
			if (first_b != noise_at(pos + 1))
			begin
				acc[kept] = first_b;
				kept++;
				run = 0;
				if (kept == `WORD_BITS)
				begin
					model_word_q.push_back(acc);
					model_fail_q.push_back(fail);
					kept = 0;
					acc = '0;
					fail = 1'b0;
				end
			end
			else
			begin
				run++;
				if (run >= `HEALTH_LIMIT)
					fail = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// UART driver and command sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic send_frame(input byte_t b);
		logic [9:0] frame;
		int i;
		// Start, data LSB first, stop
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(posedge i_Clk);
			#1;
			rx = frame[i];
			if (i == 9)
				cmd_seen = 1'b1;
			repeat (`CLKS_PER_BIT - 1) @(posedge i_Clk);
		end
		// Extra idle bit between frames
		repeat (`CLKS_PER_BIT) @(posedge i_Clk);
	endtask

	task automatic run_command(input byte_t c);
		int err_start;
		int n;
		bit have_ref;
		bit trace_ok;
		logic ref_fail;
		word_t ref_word;
		word_t asm_word;
		byte_t got;
		err_start = errors;
		have_ref = 1'b0;
		ref_fail = 1'b0;
		ref_word = '0;
		asm_word = '0;
		// Trace replies for a generate must agree with the model
		if (c == OP_GEN)
		begin
			if (model_word_q.size() == 0)
			begin
				$display("%0t: generate command without a full noise word in the trace", $time);
				errors++;
			end
			else
			begin
				ref_word = model_word_q.pop_front();
				ref_fail = model_fail_q.pop_front();
				have_ref = 1'b1;
				if (ref_fail)
					trace_ok = exp_q.size() == 1 && exp_q[0] == `REPLY_FAIL;
				else
					trace_ok = exp_q.size() == 4 &&
						{exp_q[3], exp_q[2], exp_q[1], exp_q[0]} == ref_word;
				if (!trace_ok)
				begin
					$display("%0t: trace replies disagree with the noise model", $time);
					errors++;
				end
				// A full word waits for the controller, so noise is held off
				if (noise_ready !== 1'b0)
				begin
					$display("MISMATCH %0t noise_ready got %b expected 0", $time, noise_ready);
					errors++;
				end
			end
		end
		send_frame(c);
		if (!idle_reported)
		begin
			idle_reported = 1'b1;
			tests++;
			$display("test %0d idle after reset: %s", tests, idle_bad ? "fail" : "pass");
		end
		for (n = 0; n < exp_q.size(); n++)
		begin
			while (reply_q.size() == 0)
				@(posedge i_Clk);
			got = reply_q.pop_front();
			check_byte(got, exp_q[n]);
			asm_word[8*n +: 8] = got;
		end
		// Reply done once led drops
		while (led !== 1'b0)
			@(negedge i_Clk);
		if (have_ref && !ref_fail && exp_q.size() == 4)
			check_word(asm_word, ref_word);
		tests++;
		$display("test %0d cmd %02h: %s", tests, c, (errors == err_start) ? "pass" : "fail");
	endtask

	initial
	begin
		i_Clk = 1'b0;
		rst_n = 1'b0;
		rx = 1'b1;
		noise_bit = 1'b0;
		noise_valid = 1'b0;
		load_trace();
		build_model();
		limit = 10 + TAIL_CYCLES + 40 * `CLKS_PER_BIT * trace_bytes + 64 * noise_bits;
		repeat (10) @(posedge i_Clk);
		#1;
		rst_n = 1'b1;
		rec_idx = 0;
		while (rec_idx < rec_kind.size())
		begin
			if (rec_kind[rec_idx] == "C")
			begin
				cmd = rec_val[rec_idx][7:0];
				rec_idx++;
				exp_q.delete();
				// Expected bytes up to the next command
				while (rec_idx < rec_kind.size() && rec_kind[rec_idx] != "C")
				begin
					if (rec_kind[rec_idx] == "E")
						exp_q.push_back(rec_val[rec_idx][7:0]);
					rec_idx++;
				end
				run_command(cmd);
			end
			else
				rec_idx++;
		end
		repeat (TAIL_CYCLES) @(posedge i_Clk);
		if (reply_q.size() != 0)
		begin
			$display("%0t: %0d unexpected bytes left on tx", $time, reply_q.size());
			errors++;
		end
		$display("tests %0d errors %0d", tests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Noise feeder, tx monitor, idle check, watchdog
	////////////////////////////////////////////////////////////////////////////

	// One bit per cycle, held until noise_ready takes it
	initial
	begin
		wait (rst_n === 1'b1);
		forever
		begin
			@(negedge i_Clk);
			fire = noise_valid && noise_ready;
			@(posedge i_Clk);
			#1;
			if (fire)
				noise_pos++;
			if (noise_pos < noise_bits)
			begin
				noise_valid = 1'b1;
				noise_bit = noise_at(noise_pos);
			end
			else
				noise_valid = 1'b0;
		end
	end

	// Decode tx at mid-bit on the falling clock
	initial
	begin
		wait (rst_n === 1'b1);
		forever
		begin
			@(negedge tx);
			repeat (`CLKS_PER_BIT / 2) @(negedge i_Clk);
			if (led !== 1'b1)
			begin
				$display("%0t: led is low while a reply byte is sent", $time);
				errors++;
			end
			for (mon_i = 0; mon_i < 8; mon_i++)
			begin
				repeat (`CLKS_PER_BIT) @(negedge i_Clk);
				mon_byte[mon_i] = tx;
			end
			repeat (`CLKS_PER_BIT) @(negedge i_Clk);
			if (tx !== 1'b1)
			begin
				$display("%0t: stop bit on tx is low", $time);
				errors++;
			end
			reply_q.push_back(mon_byte);
		end
	end

	// Line quiet from reset until the first command
	always @(negedge i_Clk)
	begin
		if (rst_n === 1'b1 && !cmd_seen && !idle_bad && (tx !== 1'b1 || led !== 1'b0))
		begin
			$display("%0t: tx or led active before the first command", $time);
			errors++;
			idle_bad = 1'b1;
		end
	end

	initial
	begin
		wait (limit > 0);
		while (cycle_cnt < limit)
			@(posedge i_Clk);
		$display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* trng_uart_top.sv */
// Top level of the UART random number service
// Receiver, collector, controller and transmitter on plain ports
`timescale 1ns/1ps

module trng_uart_top
(
	input  logic i_Clk,
	input  logic rst_n,
	input  logic rx,
	input  logic noise_bit,
	input  logic noise_valid,
	output logic tx,
	output logic noise_ready,
	output logic led
);

	////////////////////////////////////////////////////////////////////////////
	// Channels between the blocks
	////////////////////////////////////////////////////////////////////////////

	uart_pkg::byte_t rx_byte;
	logic            rx_valid;
	uart_pkg::byte_t tx_byte;
	logic            tx_req;
	logic            tx_ack;

	entropy_if ent ();

	////////////////////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////////////////////

	uart_rx uart_rx_i
	(
		.i_Clk    (i_Clk),
		.rst_n    (rst_n),
		.rx       (rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	entropy_collector entropy_collector_i
	(
		.i_Clk       (i_Clk),
		.rst_n       (rst_n),
		.noise_bit   (noise_bit),
		.noise_valid (noise_valid),
		.noise_ready (noise_ready),
		.ent         (ent.src)
	);

	host_controller host_controller_i
	(
		.i_Clk    (i_Clk),
		.rst_n    (rst_n),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.ent      (ent.ctrl),
		.tx_req   (tx_req),
		.tx_byte  (tx_byte),
		.tx_ack   (tx_ack),
		.led      (led)
	);

	uart_tx uart_tx_i
	(
		.i_Clk   (i_Clk),
		.rst_n   (rst_n),
		.tx_req  (tx_req),
		.tx_byte (tx_byte),
		.tx_ack  (tx_ack),
		.tx      (tx)
	);

endmodule

/* host_controller.sv */
// Host command controller
// Opcode decode, entropy word fetch, byte reply sequencing
`timescale 1ns/1ps
`include "trng_config.svh"

module host_controller
(
	input  logic            i_Clk,
	input  logic            rst_n,
	input  uart_pkg::byte_t rx_byte,
	input  logic            rx_valid,
	entropy_if.ctrl         ent,
	output logic            tx_req,
	output uart_pkg::byte_t tx_byte,
	input  logic            tx_ack,
	output logic            led
);
	import uart_pkg::*;
	import trng_pkg::*;

	ctrl_state_e state;
	byte_t       cmd;
	// Reply bytes, next one always in the low byte
	word_t       reply;
	logic [2:0]  left;

	always_ff @(posedge i_Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= IDLE;
			left    <= '0;
			ent.req <= 1'b0;
			tx_req  <= 1'b0;
			led     <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Only listening here, bytes during a reply are lost
					if (rx_valid)
					begin
						cmd   <= rx_byte;
						state <= DECODE;
					end
				end
				DECODE:
				begin
					case (opcode_e'(cmd))
						OP_GEN:
						begin
							led     <= 1'b1;
							ent.req <= 1'b1;
							state   <= REQ;
						end
						OP_PING:
						begin
							led          <= 1'b1;
							reply[7:0]   <= `REPLY_ACK;
							left         <= 3'd1;
							state        <= SEND;
						end
						default:
							state <= IDLE;
					endcase
				end
				REQ:
				begin
					if (ent.ack)
					begin
						// Failed health test replaces the whole word
						reply   <= ent.health_fail ? word_t'(`REPLY_FAIL) : ent.word;
						left    <= ent.health_fail ? 3'd1 : 3'd4;
						ent.req <= 1'b0;
						state   <= RELEASE;
					end
				end
				RELEASE:
				begin
					if (!ent.ack)
						state <= SEND;
				end
				SEND:
				begin
					// Previous byte fully closed before the next
					if (!tx_ack && left == 3'd0)
					begin
						led   <= 1'b0;
						state <= IDLE;
					end
					else if (!tx_ack)
					begin
						tx_byte <= reply[7:0];
						tx_req  <= 1'b1;
						state   <= WAIT_TX;
					end
				end
				WAIT_TX:
				begin
					if (tx_ack)
					begin
						tx_req <= 1'b0;
						reply  <= reply >> 8;
						left   <= left - 1'b1;
						state  <= SEND;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// New word request only once the last ack has cleared
	assert property (@(posedge i_Clk) disable iff (!rst_n) $rose(ent.req) |-> !ent.ack);

endmodule

/* entropy_collector.sv */
// Entropy collector
// Von Neumann pair filter, word packer, repetition health test
`timescale 1ns/1ps
`include "trng_config.svh"

module entropy_collector
(
	input  logic   i_Clk,
	input  logic   rst_n,
	input  logic   noise_bit,
	input  logic   noise_valid,
	output logic   noise_ready,
	entropy_if.src ent
);
	import trng_pkg::*;

	localparam int BIT_W = $clog2(`WORD_BITS);
	localparam int RUN_W = $clog2(`HEALTH_LIMIT);

	logic             take;
	// First half of the current pair
	logic             have_first;
	logic             first_bit;
	logic [BIT_W-1:0] kept_cnt;
	logic [RUN_W-1:0] run_cnt;
	logic             full;
	logic             ack_q;
	logic             health_q;
	word_t            word_q;

	// Back-pressure while a word waits for the controller
	assign noise_ready = !full;
	assign take        = noise_valid && noise_ready;

	assign ent.ack         = ack_q;
	assign ent.word        = word_q;
	assign ent.health_fail = health_q;

	always_ff @(posedge i_Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			have_first <= 1'b0;
			first_bit  <= 1'b0;
			kept_cnt   <= '0;
			run_cnt    <= '0;
			full       <= 1'b0;
			ack_q      <= 1'b0;
			health_q   <= 1'b0;
		end
		else
		begin
			if (take && !have_first)
			begin
				have_first <= 1'b1;
				first_bit  <= noise_bit;
			end
			else if (take)
			begin
				have_first <= 1'b0;
				if (first_bit != noise_bit)
				begin
					// 10 keeps 1, 01 keeps 0, filled from bit 0 up
					word_q   <= {first_bit, word_q[`WORD_BITS-1:1]};
					kept_cnt <= kept_cnt + 1'b1;
					run_cnt  <= '0;
					if (kept_cnt == BIT_W'(`WORD_BITS - 1))
						full <= 1'b1;
				end
				else if (run_cnt == RUN_W'(`HEALTH_LIMIT - 1))
					health_q <= 1'b1;
				else
					run_cnt <= run_cnt + 1'b1;
			end

			// Four-phase handshake toward the controller
			if (full && ent.req && !ack_q)
				ack_q <= 1'b1;
			else if (ack_q && !ent.req)
			begin
				ack_q    <= 1'b0;
				full     <= 1'b0;
				health_q <= 1'b0;
				word_q   <= '0;
			end
		end
	end

	// Word held steady for the whole ack phase
	assert property (@(posedge i_Clk) disable iff (!rst_n)
		ent.ack |=> !ent.ack || $stable(ent.word));

endmodule

/* uart_tx.sv */
// UART transmitter, 8N1, LSB first
// Byte taken on a four-phase req/ack handshake
`timescale 1ns/1ps
`include "trng_config.svh"

module uart_tx
(
	input  logic            i_Clk,
	input  logic            rst_n,
	input  logic            tx_req,
	input  uart_pkg::byte_t tx_byte,
	output logic            tx_ack,
	output logic            tx
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT) + 1;
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`CLKS_PER_BIT - 1);

	tx_state_e        state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic             req_q;
	byte_t            shift;

	always_ff @(posedge i_Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			req_q   <= 1'b0;
			tx      <= 1'b1;
			tx_ack  <= 1'b0;
		end
		else
		begin
			req_q <= tx_req;
			case (state)
				TX_IDLE:
				begin
					cnt     <= '0;
					bit_idx <= '0;
					tx      <= 1'b1;
					// New request, latch byte and open start bit
					if (tx_req && !req_q)
					begin
						shift <= tx_byte;
						tx    <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START:
				begin
					if (cnt == BIT_END)
					begin
						cnt   <= '0;
						tx    <= shift[0];
						state <= TX_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				TX_DATA:
				begin
					if (cnt == BIT_END)
					begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						shift   <= shift >> 1;
						tx      <= (bit_idx == 3'd7) ? 1'b1 : shift[1];
						if (bit_idx == 3'd7)
							state <= TX_STOP;
					end
					else
						cnt <= cnt + 1'b1;
				end
				TX_STOP:
				begin
					// Ack only after the full stop bit
					if (cnt == BIT_END)
					begin
						tx_ack <= 1'b1;
						state  <= TX_RELEASE;
					end
					else
						cnt <= cnt + 1'b1;
				end
				TX_RELEASE:
				begin
					if (!tx_req)
					begin
						tx_ack <= 1'b0;
						state  <= TX_IDLE;
					end
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	// Ack never appears without a live request behind it
	assert property (@(posedge i_Clk) disable iff (!rst_n) tx_ack |-> $past(tx_req));

endmodule

/* uart_rx.sv */
// UART receiver, 8N1, LSB first
// Two-flop input sync, mid-bit sampling, one-cycle byte strobe
`timescale 1ns/1ps
`include "trng_config.svh"

module uart_rx
(
	input  logic            i_Clk,
	input  logic            rst_n,
	input  logic            rx,
	output uart_pkg::byte_t rx_byte,
	output logic            rx_valid
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(`CLKS_PER_BIT) + 1;
	localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`CLKS_PER_BIT / 2 - 1);

	rx_state_e        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	// Stop bit sampled, now waiting out the second half
	logic             stop_seen;
	logic             stop_ok;

	always_ff @(posedge i_Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_meta   <= 1'b1;
			rx_sync   <= 1'b1;
			state     <= RX_IDLE;
			cnt       <= '0;
			bit_idx   <= '0;
			stop_seen <= 1'b0;
			stop_ok   <= 1'b0;
			rx_valid  <= 1'b0;
		end
		else
		begin
			// Line idles high, so sync flops reset to 1
			rx_meta  <= rx;
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START:
				begin
					// Middle of start bit, recheck for glitch
					if (cnt == HALF_END)
					begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (cnt == BIT_END)
					begin
						cnt     <= '0;
						rx_byte <= {rx_sync, rx_byte[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_STOP:
				begin
					if (!stop_seen && cnt == BIT_END)
					begin
						// Mid stop bit
						cnt       <= '0;
						stop_seen <= 1'b1;
						stop_ok   <= rx_sync;
					end
					else if (stop_seen && cnt == HALF_END)
					begin
						// Framing error drops the byte
						rx_valid  <= stop_ok;
						stop_seen <= 1'b0;
						state     <= RX_IDLE;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Strobe lasts exactly one cycle per frame
	assert property (@(posedge i_Clk) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

/* entropy_if.sv */
// Entropy word channel between controller and collector
// Four-phase req/ack, word and health flag stable while ack is high
`timescale 1ns/1ps

interface entropy_if;

	// Controller asks for a word
	logic req;
	// Collector holds a full word
	logic ack;
	trng_pkg::word_t word;
	// Sticky health failure, reported with the word
	logic health_fail;

	// Requesting side
	modport ctrl (output req, input ack, word, health_fail);

	// Supplying side
	modport src (input req, output ack, word, health_fail);

endinterface

/* trng_pkg.sv */
// Random number service types
// Entropy word, host opcodes and controller state encoding
`include "trng_config.svh"

package trng_pkg;

	// One packed entropy word
	typedef logic [`WORD_BITS-1:0] word_t;

	// Host command bytes
	typedef enum logic [7:0]
	{
		OP_GEN  = 8'h31,
		OP_PING = 8'h3F
	} opcode_e;

	// Controller FSM
	typedef enum logic [2:0]
	{
		IDLE,
		DECODE,
		REQ,
		RELEASE,
		SEND,
		WAIT_TX
	} ctrl_state_e;

endpackage

/* uart_pkg.sv */
// UART types
// Data byte, receiver and transmitter state encodings
package uart_pkg;

	// One serial data byte
	typedef logic [7:0] byte_t;

	// Receiver FSM
	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Transmitter FSM, RELEASE holds ack until req drops
	typedef enum logic [2:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		TX_RELEASE
	} tx_state_e;

endpackage

/* trng_config.svh */
// Design constants for the UART random number service
// UART bit timing, entropy word size, health limit and reply codes
`ifndef TRNG_CONFIG_SVH
`define TRNG_CONFIG_SVH

// Clock cycles per UART bit
`define CLKS_PER_BIT 8

// Bits per entropy word
`define WORD_BITS 32

// Consecutive discarded pairs before the health flag sets
`define HEALTH_LIMIT 32

// Ping reply
`define REPLY_ACK 8'h06
// Reply when the health test has failed
`define REPLY_FAIL 8'hEE

`endif
